/* hdl/frame_pkg.sv */
package frame_pkg;

   ////////////////////////////////////////
   // raster timing, reduced for short frames
   ////////////////////////////////////////

   // horizontal, in pixel times
   localparam int h_active     = 32;
   localparam int h_sync_start = 36;
   localparam int h_sync_end   = 44;
   localparam int h_total      = 48;

   // vertical, in lines
   localparam int v_active     = 16;
   localparam int v_sync_start = 17;
   localparam int v_sync_end   = 19;
   localparam int v_total      = 22;

   ////////////////////////////////////////
   // frame store geometry
   ////////////////////////////////////////

   // grey pixels, four to a word, lowest byte leftmost
   localparam int pixel_width     = 8;
   localparam int pixels_per_word = 4;
   localparam int word_width      = 32;
   localparam int words_per_line  = 8;
   localparam int frame_words     = 128;
   localparam int addr_width      = 7;

   // sram style pipeline and pixel path depth
   localparam int read_latency    = 2;
   localparam int display_latency = 4;

   // capture queue entries, equal to the credit count
   localparam int queue_depth = 4;

   // square marker drawn over the frozen frame
   localparam int              cursor_size  = 4;
   localparam logic [7:0]      cursor_level = 8'hff;

   typedef enum logic [1:0] {
      mode_capture,
      mode_freeze_wait,
      mode_display
   } video_mode_e;

endpackage

/* hdl/video_timing.sv */
`timescale 1ns/1ps

module video_timing
   import frame_pkg::*;
(
   input  logic       clk,
   input  logic       reset,
   output logic [5:0] hcount,
   output logic [4:0] vcount,
   output logic       hsync,
   output logic       vsync,
   output logic       blank,
   output logic       frame_start
);

   logic [5:0] h_next;
   logic [4:0] v_next;
   logic       h_wrap;

   // last pixel time of the line
   assign h_wrap = (hcount == 6'(h_total - 1));
   assign h_next = h_wrap ? 6'd0 : hcount + 6'd1;

   // line counter steps only at end of line
   always_comb begin
      if (!h_wrap) begin
         v_next = vcount;
      end else if (vcount == 5'(v_total - 1)) begin
         v_next = 5'd0;
      end else begin
         v_next = vcount + 5'd1;
      end
   end

   ////////////////////////////////////////
   // registered counters and flags
   ////////////////////////////////////////

   // flags come from the next counts so they line up with the counters
   always_ff @(posedge clk) begin
      if (reset) begin
         hcount      <= '0;
         vcount      <= '0;
         hsync       <= 1'b1;
         vsync       <= 1'b1;
         blank       <= 1'b0;
         frame_start <= 1'b0;
      end else begin
         hcount      <= h_next;
         vcount      <= v_next;
         // syncs are active low
         hsync       <= !((h_next >= 6'(h_sync_start)) && (h_next < 6'(h_sync_end)));
         vsync       <= !((v_next >= 5'(v_sync_start)) && (v_next < 5'(v_sync_end)));
         blank       <= (h_next >= 6'(h_active)) || (v_next >= 5'(v_active));
         // single pulse at the top left pixel
         frame_start <= (h_next == 6'd0) && (v_next == 5'd0);
      end
   end

endmodule

/* hdl/capture_mode_fsm.sv */
`timescale 1ns/1ps

module capture_mode_fsm
   import frame_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  logic        freeze,
   input  logic        resume,
   input  logic        frame_start,
   output video_mode_e mode,
   output logic        capture_restart
);

   video_mode_e mode_next;
   logic        resume_pending;
   logic        restart_next;

   // freeze acts at once, everything else waits for a frame edge
   always_comb begin
      mode_next    = mode;
      restart_next = 1'b0;
      case (mode)
         mode_capture: begin
            if (freeze) mode_next = mode_freeze_wait;
         end
         mode_freeze_wait: begin
            // the frame being written is complete here
            if (frame_start) mode_next = mode_display;
         end
         mode_display: begin
            if (frame_start && (resume_pending || resume)) begin
               mode_next    = mode_capture;
               restart_next = 1'b1;
            end
         end
         default: mode_next = mode_capture;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mode            <= mode_capture;
         resume_pending  <= 1'b0;
         capture_restart <= 1'b0;
      end else begin
         mode            <= mode_next;
         capture_restart <= restart_next;
         // remember resume until the next frame edge
         if (mode != mode_display || restart_next) begin
            resume_pending <= 1'b0;
         end else if (resume) begin
            resume_pending <= 1'b1;
         end
      end
   end

endmodule

/* hdl/pixel_write_queue.sv */
`timescale 1ns/1ps

module pixel_write_queue
   import frame_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  cap_valid,
   input  logic [word_width-1:0] cap_word,
   input  logic                  wr_taken,
   output logic                  wr_pending,
   output logic [word_width-1:0] wr_word,
   output logic                  cap_credit
);

   logic [word_width-1:0]          entries [queue_depth];
   logic [$clog2(queue_depth)-1:0] wr_ptr;
   logic [$clog2(queue_depth)-1:0] rd_ptr;
   logic [$clog2(queue_depth):0]   fill;
   logic                           push;

   // source only sends with a credit in hand, full check is a guard
   assign push = cap_valid && (fill != ($clog2(queue_depth) + 1)'(queue_depth));

   // queue storage
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= cap_word;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fill       <= '0;
         cap_credit <= 1'b0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (wr_taken) rd_ptr <= rd_ptr + 1'b1;
         case ({push, wr_taken})
            2'b10:   fill <= fill + 1'b1;
            2'b01:   fill <= fill - 1'b1;
            default: fill <= fill;
         endcase
         // each word the store takes frees one entry
         cap_credit <= wr_taken;
      end
   end

   // oldest word offered to the frame store
   assign wr_pending = (fill != '0);
   assign wr_word    = entries[rd_ptr];

endmodule

/* hdl/frame_store.sv */
`timescale 1ns/1ps

module frame_store
   import frame_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,
   input  video_mode_e           mode,
   input  logic                  capture_restart,
   input  logic                  rd_req,
   input  logic [addr_width-1:0] rd_addr,
   output logic [word_width-1:0] rd_data,
   input  logic                  wr_pending,
   input  logic [word_width-1:0] wr_word,
   output logic                  wr_taken
);

   logic [word_width-1:0] mem [frame_words];
   logic [word_width-1:0] rd_pipe [read_latency];
   logic [addr_width-1:0] wr_ptr;
   logic [addr_width-1:0] wr_addr;

   // reads own the port, capture uses the free slots
   assign wr_taken = !rd_req && wr_pending && (mode != mode_display);

   // a restart writes its first word at the top of the frame
   assign wr_addr = capture_restart ? '0 : wr_ptr;

   ////////////////////////////////////////
   // single port array and read pipeline
   ////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (wr_taken) begin
         mem[wr_addr] <= wr_word;
      end
      if (rd_req) begin
         rd_pipe[0] <= mem[rd_addr];
      end
      for (int i = 1; i < read_latency; i++) begin
         rd_pipe[i] <= rd_pipe[i-1];
      end
   end

   assign rd_data = rd_pipe[read_latency-1];

   // capture write pointer, wraps at the end of the frame
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
      end else if (wr_taken) begin
         wr_ptr <= (wr_addr == addr_width'(frame_words - 1)) ? '0 : wr_addr + 1'b1;
      end else if (capture_restart) begin
         wr_ptr <= '0;
      end
   end

endmodule

/* hdl/display_fetch.sv */
`timescale 1ns/1ps

module display_fetch
   import frame_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   input  video_mode_e            mode,
   input  logic [5:0]             hcount,
   input  logic [4:0]             vcount,
   input  logic                   hsync,
   input  logic                   vsync,
   input  logic                   blank,
   input  logic [5:0]             cursor_x,
   input  logic [4:0]             cursor_y,
   output logic                   rd_req,
   output logic [addr_width-1:0]  rd_addr,
   input  logic [word_width-1:0]  rd_data,
   output logic [pixel_width-1:0] vga_pixel,
   output logic                   vga_hsync,
   output logic                   vga_vsync,
   output logic                   vga_blank
);

   // counters and flags travel together as one vector
   logic [13:0]            timing_in;
   logic [13:0]            timing_pipe [display_latency-1];
   logic [5:0]             h_d;
   logic [4:0]             v_d;
   logic                   hs_d;
   logic                   vs_d;
   logic                   blank_d;
   logic                   word_start;
   logic                   cursor_hit;
   logic [word_width-1:0]  shift_word;
   logic [pixel_width-1:0] pixel_src;

   ////////////////////////////////////////
   // read scheduling
   ////////////////////////////////////////

   // one request per four active pixels, data back three cycles later
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_req  <= 1'b0;
         rd_addr <= '0;
      end else begin
         rd_req  <= !blank && (hcount % pixels_per_word == 0);
         rd_addr <= addr_width'(vcount * words_per_line + hcount / pixels_per_word);
      end
   end

   // delay line, one stage short of display_latency
   assign timing_in = {hcount, vcount, hsync, vsync, blank};

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < display_latency - 1; i++) begin
            timing_pipe[i] <= {11'd0, 3'b111};
         end
      end else begin
         timing_pipe[0] <= timing_in;
         for (int i = 1; i < display_latency - 1; i++) begin
            timing_pipe[i] <= timing_pipe[i-1];
         end
      end
   end

   assign {h_d, v_d, hs_d, vs_d, blank_d} = timing_pipe[display_latency-2];

   ////////////////////////////////////////
   // unpack and overlay
   ////////////////////////////////////////

   // rd_data is valid in the cycle the delayed counter hits a word start
   assign word_start = !blank_d && (h_d % pixels_per_word == 0);
   assign pixel_src  = word_start ? rd_data[pixel_width-1:0] : shift_word[pixel_width-1:0];

   // remaining bytes shift down, leftmost first
   always_ff @(posedge clk) begin
      if (word_start) begin
         shift_word <= rd_data >> pixel_width;
      end else begin
         shift_word <= shift_word >> pixel_width;
      end
   end

   // marker square with its top left at the cursor
   assign cursor_hit = (h_d >= cursor_x) && ((h_d - cursor_x) < 6'(cursor_size)) &&
                       (v_d >= cursor_y) && ((v_d - cursor_y) < 5'(cursor_size));

   always_ff @(posedge clk) begin
      if (reset) begin
         vga_pixel <= '0;
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
         vga_blank <= 1'b1;
      end else begin
         vga_hsync <= hs_d;
         vga_vsync <= vs_d;
         vga_blank <= blank_d;
         // black in blanking and while capturing
         if (blank_d || mode != mode_display) begin
            vga_pixel <= '0;
         end else if (cursor_hit) begin
            vga_pixel <= cursor_level;
         end else begin
            vga_pixel <= pixel_src;
         end
      end
   end

endmodule

/* hdl/video_frame_top.sv */
`timescale 1ns/1ps

module video_frame_top
   import frame_pkg::*;
(
   input  logic                   clk,
   input  logic                   reset,
   // capture source, credit based
   input  logic                   cap_valid,
   input  logic [word_width-1:0]  cap_word,
   output logic                   cap_credit,
   // mode control and marker position
   input  logic                   freeze,
   input  logic                   resume,
   input  logic [5:0]             cursor_x,
   input  logic [4:0]             cursor_y,
   // video out
   output logic [pixel_width-1:0] vga_pixel,
   output logic                   vga_hsync,
   output logic                   vga_vsync,
   output logic                   vga_blank
);

   // raster
   logic [5:0]            hcount;
   logic [4:0]            vcount;
   logic                  hsync;
   logic                  vsync;
   logic                  blank;
   logic                  frame_start;

   // mode
   video_mode_e           mode;
   logic                  capture_restart;

   // store ports
   logic                  wr_pending;
   logic [word_width-1:0] wr_word;
   logic                  wr_taken;
   logic                  rd_req;
   logic [addr_width-1:0] rd_addr;
   logic [word_width-1:0] rd_data;

   video_timing video_timing_inst (
      .clk         (clk),
      .reset       (reset),
      .hcount      (hcount),
      .vcount      (vcount),
      .hsync       (hsync),
      .vsync       (vsync),
      .blank       (blank),
      .frame_start (frame_start)
   );

   capture_mode_fsm capture_mode_fsm_inst (
      .clk             (clk),
      .reset           (reset),
      .freeze          (freeze),
      .resume          (resume),
      .frame_start     (frame_start),
      .mode            (mode),
      .capture_restart (capture_restart)
   );

   pixel_write_queue pixel_write_queue_inst (
      .clk        (clk),
      .reset      (reset),
      .cap_valid  (cap_valid),
      .cap_word   (cap_word),
      .wr_taken   (wr_taken),
      .wr_pending (wr_pending),
      .wr_word    (wr_word),
      .cap_credit (cap_credit)
   );

   frame_store frame_store_inst (
      .clk             (clk),
      .reset           (reset),
      .mode            (mode),
      .capture_restart (capture_restart),
      .rd_req          (rd_req),
      .rd_addr         (rd_addr),
      .rd_data         (rd_data),
      .wr_pending      (wr_pending),
      .wr_word         (wr_word),
      .wr_taken        (wr_taken)
   );

   display_fetch display_fetch_inst (
      .clk       (clk),
      .reset     (reset),
      .mode      (mode),
      .hcount    (hcount),
      .vcount    (vcount),
      .hsync     (hsync),
      .vsync     (vsync),
      .blank     (blank),
      .cursor_x  (cursor_x),
      .cursor_y  (cursor_y),
      .rd_req    (rd_req),
      .rd_addr   (rd_addr),
      .rd_data   (rd_data),
      .vga_pixel (vga_pixel),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync),
      .vga_blank (vga_blank)
   );

endmodule

/* tests/video_frame_properties.sv */
`timescale 1ns/1ps

module video_frame_properties
   import frame_pkg::*;
(
   input logic        clk,
   input logic        reset,
   input logic        cap_valid,
   input logic        cap_credit,
   input video_mode_e mode,
   input logic        vga_hsync,
   input logic        vga_vsync,
   input logic        vga_blank
);

   // words handed to the queue and not yet credited back
   int outstanding;

   always_ff @(posedge clk) begin
      if (reset) begin
         outstanding <= 0;
      end else begin
         outstanding <= outstanding + (cap_valid ? 1 : 0) - (cap_credit ? 1 : 0);
      end
   end

   // the source stalls for the whole time the frozen frame is shown
   no_credit_in_display: assert property (@(posedge clk) disable iff (reset)
      cap_credit |-> mode != mode_display)
      else $error("credit returned while in display mode");

   sync_inside_blank: assert property (@(posedge clk) disable iff (reset)
      (!vga_hsync || !vga_vsync) |-> vga_blank)
      else $error("sync pulse outside the blanking interval");

   credit_bound: assert property (@(posedge clk) disable iff (reset)
      outstanding <= queue_depth)
      else $error("more words outstanding than the queue holds");

endmodule

bind video_frame_top video_frame_properties video_frame_properties_inst (
   .clk        (clk),
   .reset      (reset),
   .cap_valid  (cap_valid),
   .cap_credit (cap_credit),
   .mode       (mode),
   .vga_hsync  (vga_hsync),
   .vga_vsync  (vga_vsync),
   .vga_blank  (vga_blank)
);

/* tests/video_frame_tb.sv */
`timescale 1ns/1ps

module video_frame_tb
   import frame_pkg::*;
();

   logic                   clk;
   logic                   reset;
   logic                   cap_valid;
   logic [word_width-1:0]  cap_word;
   logic                   cap_credit;
   logic                   freeze;
   logic                   resume;
   logic [5:0]             cursor_x;
   logic [4:0]             cursor_y;
   logic [pixel_width-1:0] vga_pixel;
   logic                   vga_hsync;
   logic                   vga_vsync;
   logic                   vga_blank;

   // twelve frame times at 20 ns per pixel
   localparam int watchdog_ns = 12 * h_total * v_total * 20;

   // what the store should hold and the copy shown after a freeze
   logic [word_width-1:0] model [frame_words];
   logic [word_width-1:0] shown [frame_words];
   int                    model_ptr = 0;
   logic [31:0]           seed = 32'hadb3;
   int                    sent_count = 0;
   int                    credit_count = 0;
   int                    credits_before;
   int                    error_count = 0;
   string                 test_name = "capture blanking";
   bit                    show_display = 1'b0;
   int                    exp_cx = 63;
   int                    exp_cy = 31;
   // raster position and sync counts seen on the outputs
   int                    x_pos = 0;
   int                    y_pos = 0;
   int                    hs_low = 0;
   int                    vs_low = 0;
   int                    hs_pulses = 0;
   int                    frames = 0;

   video_frame_top video_frame_top_inst (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      #(watchdog_ns);
      $display("Timeout: the run did not reach its end within twelve frame times");
      $display("Simulation FAILED");
      $fatal(1, "watchdog expired");
   end

   ////////////////////////////////////////
   // reference model and checks
   ////////////////////////////////////////

   function automatic logic [31:0] lcg_next(input logic [31:0] state);
      return state * 32'd1103515245 + 32'd12345;
   endfunction

   // grey level expected at (x, y) for the given mode and marker corner
   function automatic logic [7:0] expected_pixel(input int x, input int y, input bit display,
                                                 input int cx, input int cy);
      logic [31:0] word;
      word = shown[y * words_per_line + x / pixels_per_word];
      if (!display) return 8'h00;
      if (x >= cx && x < cx + cursor_size && y >= cy && y < cy + cursor_size) begin
         return cursor_level;
      end
      // lowest byte is the leftmost pixel
      return word[pixel_width * (x % pixels_per_word) +: pixel_width];
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      if (expected !== actual) begin
         error_count++;
         $display("Fail %s: expected %0h, actual %0h", name, expected, actual);
         $display("Simulation FAILED");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // credits come back one per word and never outnumber the words sent
   always @(negedge clk) begin
      if (!reset && cap_credit) begin
         check_value("credit return", 1, credit_count < sent_count);
         credit_count++;
      end
   end

   // outputs change on the rising edge and are sampled on the falling one
   always @(negedge clk) begin
      if (!reset) begin
         if (!vga_blank) begin
            if (x_pos < h_active && y_pos < v_active) begin
               check_value($sformatf("%s at %0d,%0d", test_name, x_pos, y_pos),
                           expected_pixel(x_pos, y_pos, show_display, exp_cx, exp_cy),
                           vga_pixel);
            end
            x_pos++;
         end else if (x_pos != 0) begin
            check_value("line length", h_active, x_pos);
            x_pos = 0;
            y_pos++;
         end
         if (!vga_hsync) begin
            hs_low++;
         end else if (hs_low != 0) begin
            check_value("hsync width", h_sync_end - h_sync_start, hs_low);
            hs_low = 0;
            hs_pulses++;
         end
         if (!vga_vsync) begin
            // start of vsync closes the frame
            if (vs_low == 0) begin
               check_value("active lines", v_active, y_pos);
               if (frames != 0) check_value("hsync per frame", v_total, hs_pulses);
               y_pos = 0;
               hs_pulses = 0;
               frames++;
            end
            vs_low++;
         end else if (vs_low != 0) begin
            check_value("vsync width", (v_sync_end - v_sync_start) * h_total, vs_low);
            vs_low = 0;
         end
      end
   end

   ////////////////////////////////////////
   // stimulus
   ////////////////////////////////////////

   // one word per cycle while a credit is held
   task automatic send_words(input int count);
      int i;
      i = 0;
      while (i < count) begin
         @(posedge clk);
         if (sent_count - credit_count < queue_depth) begin
            seed = lcg_next(seed);
            cap_valid <= 1'b1;
            cap_word  <= seed;
            model[model_ptr] = seed;
            model_ptr = (model_ptr + 1) % frame_words;
            sent_count++;
            i++;
         end else begin
            cap_valid <= 1'b0;
         end
      end
      @(posedge clk);
      cap_valid <= 1'b0;
   endtask

   task automatic wait_credits();
      while (credit_count != sent_count) @(posedge clk);
   endtask

   // request during vsync so the change lands on the next frame
   task automatic request_at_vsync(input bit to_display);
      @(negedge vga_vsync);
      @(posedge clk);
      freeze <= to_display;
      resume <= !to_display;
      @(posedge clk);
      freeze <= 1'b0;
      resume <= 1'b0;
   endtask

   // the next visible frame is in the new mode
   task automatic follow_mode(input bit to_display);
      @(posedge vga_vsync);
      @(posedge clk);
      show_display = to_display;
      if (to_display) shown = model;
   endtask

   initial begin
      reset     = 1'b1;
      cap_valid = 1'b0;
      cap_word  = '0;
      freeze    = 1'b0;
      resume    = 1'b0;
      cursor_x  = 6'd63;
      cursor_y  = 5'd31;
      repeat (4) @(posedge clk);
      reset <= 1'b0;

      // first frame while the output stays black
      // two extra words leave the write pointer away from 0
      send_words(frame_words + 2);
      wait_credits();
      request_at_vsync(1'b1);
      follow_mode(1'b1);
      test_name = "frozen frame";

      // marker inside the picture for one frame
      @(posedge vga_vsync);
      @(posedge clk);
      cursor_x <= 6'd10;
      cursor_y <= 5'd5;
      exp_cx = 10;
      exp_cy = 5;
      test_name = "cursor";

      // words sent in display wait in the queue until capture restarts at 0
      model_ptr = 0;
      send_words(queue_depth);
      credits_before = credit_count;
      request_at_vsync(1'b0);
      check_value("credits held in display", credits_before, credit_count);
      follow_mode(1'b0);
      test_name = "resume";
      wait_credits();

      // second frame with the marker away again
      send_words(frame_words);
      wait_credits();
      @(posedge clk);
      cursor_x <= 6'd63;
      cursor_y <= 5'd31;
      exp_cx = 63;
      exp_cy = 31;
      request_at_vsync(1'b1);
      follow_mode(1'b1);
      test_name = "second frame";
      @(posedge vga_vsync);
      @(negedge clk);

      if (error_count == 0) begin
         $display("Simulation PASSED");
         $finish;
      end else begin
         $display("Simulation FAILED");
         $fatal(1, "errors were found");
      end
   end

endmodule

/* verilog.f */
hdl/frame_pkg.sv
hdl/video_timing.sv
hdl/capture_mode_fsm.sv
hdl/pixel_write_queue.sv
hdl/frame_store.sv
hdl/display_fetch.sv
hdl/video_frame_top.sv
tests/video_frame_properties.sv
tests/video_frame_tb.sv

/* Bender.yml */
package:
  name: video_frame

sources:
  - files:
      - hdl/frame_pkg.sv
      - hdl/video_timing.sv
      - hdl/capture_mode_fsm.sv
      - hdl/pixel_write_queue.sv
      - hdl/frame_store.sv
      - hdl/display_fetch.sv
      - hdl/video_frame_top.sv
  - target: test
    files:
      - tests/video_frame_properties.sv
      - tests/video_frame_tb.sv
